/* run_sim.sh */
#!/bin/sh
# build with Verilator and run, exit status follows the testbench verdict
out=$(verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
        --top-module tb_sdram_rd_ctrl -f vlog.f -o sim_tb 2>&1 \
        && ./obj_dir/sim_tb 2>&1) \
    || { echo "$out"; echo "build or simulation did not complete"; exit 1; }
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && exit 0 || exit 1

/* sdram_addr_pkg.sv */
// host address layout and the request and data types, imported by the decoder, banks, arbiter and top
package sdram_addr_pkg;

    localparam int NBANK   = 4;
    localparam int BANK_W  = 2;
    localparam int ROW_W   = 13;
    localparam int COL_W   = 9;                 // sdram column, A[8:0]
    localparam int WCOL_W  = 7;                 // host word column
    localparam int HOST_AW = 22;
    localparam int BEAT_W  = 16;
    localparam int WORD_W  = 32;

    typedef logic [BANK_W-1:0]  bank_t;
    typedef logic [ROW_W-1:0]   row_t;
    typedef logic [COL_W-1:0]   col_t;          // always even, one word is two beats
    typedef logic [HOST_AW-1:0] host_addr_t;
    typedef logic [BEAT_W-1:0]  beat_t;
    typedef logic [WORD_W-1:0]  word_t;

    // host address split, top down: bank, row, word column
    localparam int ROW_LSB  = WCOL_W;
    localparam int BANK_LSB = WCOL_W + ROW_W;

    // request as seen by every bank machine
    typedef struct packed {
        row_t row;
        col_t col;
    } bank_req_t;

endpackage

/* sdram_bank.sv */
// per-bank machine of the read controller, keeps a row open and requests precharge, activate and read
module sdram_bank (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd,
    input  sdram_addr_pkg::bank_req_t  req,
    input  logic                       bg,
    input  logic                       all_act,
    input  logic                       all_dbusy,
    output logic                       br,
    output logic                       ack,
    output sdram_cmd_pkg::sdram_bus_t  bus
);
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRE_WAIT,
        ST_ACT_WAIT,
        ST_READ
    } bank_st_t;

    bank_st_t st;
    row_t     open_row;
    logic     prechd;       // bank closed, no row open
    tcnt_t    wait_cnt;

    logic hit;
    logic want_pre;
    logic want_act;
    logic want_rd;

    // what this bank would put on the bus right now
    always_comb begin
        hit      = !prechd && (open_row == req.row);
        want_pre = (st == ST_IDLE) && rd && !prechd && !hit;
        want_act = (st == ST_IDLE) && rd && prechd && !all_act;
        // row hit from idle, or the read after a fresh activate
        want_rd  = rd && !all_dbusy && (((st == ST_IDLE) && hit) || (st == ST_READ));
    end

    // br only when the command can go out this cycle,
    // so a grant never idles the bus
    assign br  = want_pre | want_act | want_rd;
    assign ack = bg & want_rd;              // read leaves the bank, request is done

    always_comb begin
        bus = '0;                           // merged by OR in the arbiter
        if (bg) begin
            if (want_pre) begin
                bus.cmd = CMD_PRECHARGE;    // A10 low, this bank only
            end else if (want_act) begin
                bus.cmd = CMD_ACTIVE;
                bus.a   = req.row;
            end else if (want_rd) begin
                bus.cmd = CMD_READ;
                bus.a   = sdram_a_t'(req.col);  // A10 low, no auto precharge
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= ST_IDLE;
            prechd   <= 1'b1;
            wait_cnt <= '0;
        end else begin
            case (st)
                ST_IDLE: begin
                    if (bg && want_pre) begin
                        prechd   <= 1'b1;
                        wait_cnt <= tcnt_t'(T_RP - 2);
                        st       <= ST_PRE_WAIT;
                    end else if (bg && want_act) begin
                        prechd   <= 1'b0;
                        wait_cnt <= tcnt_t'(T_RCD - 2);
                        st       <= ST_ACT_WAIT;
                    end
                end
                // back to idle, which then activates since prechd is set
                ST_PRE_WAIT: begin
                    if (wait_cnt == '0) begin
                        st <= ST_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                ST_ACT_WAIT: begin
                    if (wait_cnt == '0) begin
                        st <= ST_READ;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                ST_READ: begin
                    if (bg && want_rd) begin
                        st <= ST_IDLE;
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    // row register is only meaningful while prechd is low
    always_ff @(posedge clk) begin
        if (bg && want_act) begin
            open_row <= req.row;
        end
    end

endmodule

/* sdram_bus_arbiter.sv */
// output side of the read controller, grants and registers the command bus and captures read data
module sdram_bus_arbiter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [sdram_addr_pkg::NBANK-1:0] br,
    input  sdram_cmd_pkg::sdram_bus_t        bank_bus [sdram_addr_pkg::NBANK],
    input  sdram_addr_pkg::beat_t            dq,
    output logic [sdram_addr_pkg::NBANK-1:0] bg,
    output logic                             all_act,
    output logic                             all_dbusy,
    output sdram_cmd_pkg::sdram_bus_t        sdram,
    output sdram_addr_pkg::bank_t            ba,
    output sdram_addr_pkg::word_t            dout,
    output logic                             data_ok
);
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    logic              granted;
    bank_t             grant_bank;
    sdram_bus_t        merged;
    logic              issue_act;
    logic              issue_rd;
    tcnt_t             act_cnt;     // tRRD window
    tcnt_t             dbusy_cnt;   // data bus reservation
    logic [CAS_LAT+1:0] rd_sr;      // bit k set k+1 cycles after a read was granted
    beat_t             beat_lo;

    // fixed priority, bank 0 first
    always_comb begin
        bg         = '0;
        granted    = 1'b0;
        grant_bank = '0;
        merged     = '0;
        for (int i = 0; i < NBANK; i++) begin
            if (br[i] && !granted) begin
                bg[i]      = 1'b1;
                granted    = 1'b1;
                grant_bank = bank_t'(i);
            end
            merged = merged | bank_bus[i];
        end
    end

    assign issue_act = granted && (merged.cmd == CMD_ACTIVE);
    assign issue_rd  = granted && (merged.cmd == CMD_READ);
    assign all_act   = (act_cnt != '0);
    assign all_dbusy = (dbusy_cnt != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram     <= BUS_NOP;
            ba        <= '0;
            act_cnt   <= '0;
            dbusy_cnt <= '0;
            rd_sr     <= '0;
            data_ok   <= 1'b0;
        end else begin
            sdram <= granted ? merged : BUS_NOP;
            ba    <= granted ? grant_bank : ba;
            if (issue_act) begin
                act_cnt <= tcnt_t'(T_RRD - 1);
            end else if (act_cnt != '0) begin
                act_cnt <= act_cnt - 1'b1;
            end
            if (issue_rd) begin
                dbusy_cnt <= tcnt_t'(BURST - 1);
            end else if (dbusy_cnt != '0) begin
                dbusy_cnt <= dbusy_cnt - 1'b1;
            end
            rd_sr   <= {rd_sr[CAS_LAT:0], issue_rd};
            data_ok <= rd_sr[CAS_LAT+1];    // second beat on dq now
        end
    end

    always_ff @(posedge clk) begin
        if (rd_sr[CAS_LAT]) begin
            beat_lo <= dq;
        end
        if (rd_sr[CAS_LAT+1]) begin
            dout <= {dq, beat_lo};          // low beat in low half
        end
    end

endmodule

/* sdram_cmd_pkg.sv */
// SDRAM command encodings, device timing and the command bus type, imported by the banks and arbiter
package sdram_cmd_pkg;

    // command lines in pin order: cs_n, ras_n, cas_n, we_n
    typedef logic [3:0] sdram_cmd_t;

    localparam sdram_cmd_t CMD_NOP       = 4'b0111;
    localparam sdram_cmd_t CMD_PRECHARGE = 4'b0010;
    localparam sdram_cmd_t CMD_ACTIVE    = 4'b0011;
    localparam sdram_cmd_t CMD_READ      = 4'b0101;

    localparam int SDRAM_AW = 13;               // A[12:0]
    typedef logic [SDRAM_AW-1:0] sdram_a_t;

    // device timing in clock cycles, counted command to command on the pins
    localparam int T_RP    = 2;                 // precharge to activate
    localparam int T_RCD   = 2;                 // activate to read
    localparam int T_RRD   = 2;                 // activate to activate, any bank
    localparam int CAS_LAT = 2;                 // read to first beat
    localparam int BURST   = 2;                 // beats per read

    // wide enough for any of the wait times above
    typedef logic [1:0] tcnt_t;

    // one slot on the shared command bus
    typedef struct packed {
        sdram_cmd_t cmd;
        sdram_a_t   a;
    } sdram_bus_t;

    // what the pins carry when no bank holds the grant
    localparam sdram_bus_t BUS_NOP = '{cmd: CMD_NOP, a: '0};

endpackage

/* sdram_rd_ctrl.sv */
// top of the read-only SDRAM controller, joins the request decoder, four bank machines and the bus arbiter
module sdram_rd_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  sdram_addr_pkg::host_addr_t addr,
    input  logic                       rd,
    input  sdram_addr_pkg::beat_t      dq,
    output logic                       ack,
    output sdram_addr_pkg::word_t      dout,
    output logic                       data_ok,
    output sdram_cmd_pkg::sdram_cmd_t  sdram_cmd,
    output sdram_cmd_pkg::sdram_a_t    sdram_a,
    output sdram_addr_pkg::bank_t      sdram_ba
);
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    logic [NBANK-1:0] rd_bank;
    logic [NBANK-1:0] bank_ack;
    logic [NBANK-1:0] br;
    logic [NBANK-1:0] bg;
    bank_req_t        bank_req;
    sdram_bus_t       bank_bus [NBANK];
    sdram_bus_t       sdram_bus;
    logic             all_act;
    logic             all_dbusy;

    sdram_req_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .rd       (rd),
        .rd_bank  (rd_bank),
        .bank_req (bank_req),
        .ack      (ack),
        .bank_ack (bank_ack)
    );

    for (genvar i = 0; i < NBANK; i++) begin : g_bank
        sdram_bank u_bank (
            .clk       (clk),
            .rst       (rst),
            .rd        (rd_bank[i]),
            .req       (bank_req),
            .bg        (bg[i]),
            .all_act   (all_act),
            .all_dbusy (all_dbusy),
            .br        (br[i]),
            .ack       (bank_ack[i]),
            .bus       (bank_bus[i])
        );
    end

    sdram_bus_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .br        (br),
        .bank_bus  (bank_bus),
        .dq        (dq),
        .bg        (bg),
        .all_act   (all_act),
        .all_dbusy (all_dbusy),
        .sdram     (sdram_bus),
        .ba        (sdram_ba),
        .dout      (dout),
        .data_ok   (data_ok)
    );

    assign sdram_cmd = sdram_bus.cmd;
    assign sdram_a   = sdram_bus.a;

endmodule

/* sdram_rd_ctrl_sva.sv */
// command pin assertions for the read controller, bound into its top level in simulation
module sdram_rd_ctrl_sva (
    input logic                      clk,
    input logic                      rst,
    input sdram_cmd_pkg::sdram_cmd_t sdram_cmd,
    input sdram_addr_pkg::bank_t     sdram_ba
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    typedef logic [2:0] gap_t;      // cycles since a command, saturating

    gap_t since_act [NBANK];
    gap_t since_pre [NBANK];
    gap_t since_any_act;

    function automatic gap_t next_gap(gap_t g, logic seen);
        if (seen) return gap_t'(1);
        return (g == '1) ? g : g + gap_t'(1);
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            since_act     <= '{default: '1};
            since_pre     <= '{default: '1};
            since_any_act <= '1;
        end else begin
            for (int i = 0; i < NBANK; i++) begin
                since_act[i] <= next_gap(since_act[i],
                                         sdram_cmd == CMD_ACTIVE && sdram_ba == bank_t'(i));
                since_pre[i] <= next_gap(since_pre[i],
                                         sdram_cmd == CMD_PRECHARGE && sdram_ba == bank_t'(i));
            end
            since_any_act <= next_gap(since_any_act, sdram_cmd == CMD_ACTIVE);
        end
    end

    a_trcd: assert property (@(posedge clk) disable iff (rst)
        sdram_cmd == CMD_READ |-> since_act[sdram_ba] >= gap_t'(T_RCD))
        else $error("READ on bank %0d too soon after its ACTIVE", sdram_ba);

    a_trp: assert property (@(posedge clk) disable iff (rst)
        sdram_cmd == CMD_ACTIVE |-> since_pre[sdram_ba] >= gap_t'(T_RP))
        else $error("ACTIVE on bank %0d too soon after its PRECHARGE", sdram_ba);

    // any two banks
    a_trrd: assert property (@(posedge clk) disable iff (rst)
        sdram_cmd == CMD_ACTIVE |-> since_any_act >= gap_t'(T_RRD))
        else $error("ACTIVE on bank %0d too soon after the previous ACTIVE", sdram_ba);

endmodule

bind sdram_rd_ctrl sdram_rd_ctrl_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .sdram_cmd (sdram_cmd),
    .sdram_ba  (sdram_ba)
);

/* sdram_req_decode.sv */
// input side of the read controller, splits the host address and routes the read level to one bank
module sdram_req_decode (
    input  logic                               clk,
    input  logic                               rst,
    input  sdram_addr_pkg::host_addr_t         addr,
    input  logic                               rd,
    output logic [sdram_addr_pkg::NBANK-1:0]   rd_bank,
    output sdram_addr_pkg::bank_req_t          bank_req,
    output logic                               ack,
    input  logic [sdram_addr_pkg::NBANK-1:0]   bank_ack
);
    import sdram_addr_pkg::*;

    bank_t bank;
    logic  ack_q;       // host still sees its old request this cycle

    always_comb begin
        bank         = addr[BANK_LSB +: BANK_W];
        bank_req.row = addr[ROW_LSB +: ROW_W];
        // word column times two gives the even sdram column
        bank_req.col = col_t'({addr[WCOL_W-1:0], 1'b0});
    end

    // one-hot steering, held off right after an ack
    always_comb begin
        rd_bank       = '0;
        rd_bank[bank] = rd & ~ack_q;
    end

    assign ack = |bank_ack;     // at most one bank acks per cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= ack;
        end
    end

endmodule

/* tb_sdram_rd_ctrl.sv */
// directed testbench for the read-only SDRAM controller with a behavioral SDRAM answering reads on dq
module tb_sdram_rd_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int N_READS      = 37;           // 1 + 1 + 1 + 4 + 30
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 8 + 40 * N_READS;

    // one command as seen on the pins
    typedef struct packed {
        sdram_cmd_t cmd;
        bank_t      ba;
        sdram_a_t   a;
    } pin_cmd_t;

    logic       clk  = 1'b0;
    logic       rst  = 1'b1;
    host_addr_t addr = '0;
    logic       rd   = 1'b0;
    beat_t      dq   = '0;
    logic       ack;
    logic       data_ok;
    word_t      dout;
    sdram_cmd_t sdram_cmd;
    sdram_a_t   sdram_a;
    bank_t      sdram_ba;

    int       cycle     = 0;
    int       err_count = 0;
    int       err_base  = 0;
    int       tests_run = 0;
    int       ack_cyc;
    pin_cmd_t cmd_log [$];                  // non-NOP commands only
    word_t    exp_q [$];
    word_t    got_q [$];
    int       got_cyc [$];
    row_t     rsp_row [NBANK];              // row the model holds open per bank
    beat_t    rsp_beat [CAS_LAT+2];         // dq schedule with slot 0 as this cycle

    sdram_rd_ctrl UUT (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .rd        (rd),
        .dq        (dq),
        .ack       (ack),
        .dout      (dout),
        .data_ok   (data_ok),
        .sdram_cmd (sdram_cmd),
        .sdram_a   (sdram_a),
        .sdram_ba  (sdram_ba)
    );

    always #10 clk = ~clk;

    // memory content as a 16-bit mix of bank, row, column and beat index
    function automatic beat_t beat_of(bank_t b, row_t r, col_t c, logic idx);
        return {r, 3'b101} ^ {c, 5'h00, b} ^ (idx ? 16'hc35a : 16'h0f11);
    endfunction

    // bank on top then row then word column
    function automatic word_t expect_word(host_addr_t ha);
        bank_t b;
        row_t  r;
        col_t  c;
        b = ha[21:20];
        r = ha[19:7];
        c = col_t'(ha[6:0]) << 1;
        return {beat_of(b, r, c, 1'b1), beat_of(b, r, c, 1'b0)};  // low beat in low half
    endfunction

    // behavioral SDRAM that drives the two beats CAS_LAT cycles after a READ on the pins
    always @(posedge clk) begin
        #1;
        for (int k = 0; k < CAS_LAT + 1; k++) begin
            rsp_beat[k] = rsp_beat[k+1];
        end
        rsp_beat[CAS_LAT+1] = '0;
        if (rst) begin
            rsp_beat = '{default: '0};
        end else if (sdram_cmd == CMD_ACTIVE) begin
            rsp_row[sdram_ba] = row_t'(sdram_a);
        end else if (sdram_cmd == CMD_READ) begin
            rsp_beat[CAS_LAT]   = beat_of(sdram_ba, rsp_row[sdram_ba], col_t'(sdram_a), 1'b0);
            rsp_beat[CAS_LAT+1] = beat_of(sdram_ba, rsp_row[sdram_ba], col_t'(sdram_a), 1'b1);
        end
        dq = rsp_beat[0];
    end

    // mid-cycle monitor of the pins and the read data
    always @(negedge clk) begin
        if (!rst && sdram_cmd != CMD_NOP) cmd_log.push_back({sdram_cmd, sdram_ba, sdram_a});
        if (!rst && data_ok) begin
            got_q.push_back(dout);
            got_cyc.push_back(cycle);
        end
    end

    initial begin
        while (cycle < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout after %0d cycles, the controller stopped answering", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic fail_value(string test, string what, logic [31:0] exp, logic [31:0] act);
        $display("FAIL %s: %s expected %h actual %h", test, what, exp, act);
        err_count++;
    endtask

    task automatic start_test();
        cmd_log.delete();
        got_q.delete();
        got_cyc.delete();
        err_base = err_count;
    endtask

    task automatic end_test(string test);
        tests_run++;
        if (err_count == err_base) $display("test %s: passed", test);
        else $display("test %s: %0d failed checks", test, err_count - err_base);
    endtask

    // holds rd until ack and returns one cycle later at the drive point
    task automatic do_read(host_addr_t ha);
        addr = ha;
        rd   = 1'b1;
        exp_q.push_back(expect_word(ha));
        @(negedge clk);
        while (!ack) @(negedge clk);
        ack_cyc = cycle;
        @(posedge clk);
        #1;
        rd = 1'b0;
    endtask

    // waits for every outstanding word and compares in issue order
    task automatic finish_reads(string test);
        word_t exp;
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk);
            #1;
        end
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            if (got_q[0] !== exp) fail_value(test, "read word", exp, got_q[0]);
            got_q.delete(0);
        end
    endtask

    task automatic check_cmd(string test, int idx, sdram_cmd_t cmd, bank_t ba, sdram_a_t a);
        if (idx >= cmd_log.size()) begin
            $display("FAIL %s: command %0d never appeared on the pins", test, idx);
            err_count++;
        end else if (cmd_log[idx] !== {cmd, ba, a}) begin
            fail_value(test, $sformatf("command %0d", idx), {cmd, ba, a}, cmd_log[idx]);
        end
    endtask

    // a read is held pending through the reset and dropped as it ends
    task automatic reset_outputs();
        start_test();
        for (int i = 0; i < RESET_CYCLES + 2; i++) begin
            @(posedge clk);
            #1;
            rst = (i < RESET_CYCLES - 1);
            rd  = rst;
            @(negedge clk);
            if (sdram_cmd !== CMD_NOP) fail_value("reset", "cmd", CMD_NOP, sdram_cmd);
            if (ack !== 1'b0) fail_value("reset", "ack", 0, ack);
            if (data_ok !== 1'b0) fail_value("reset", "data_ok", 0, data_ok);
        end
        @(posedge clk);
        #1;
        end_test("reset");
    endtask

    task automatic closed_bank_read();
        start_test();
        do_read({2'd1, 13'h0123, 7'd5});
        finish_reads("closed_bank");
        if (cmd_log.size() != 2) fail_value("closed_bank", "command count", 2, cmd_log.size());
        check_cmd("closed_bank", 0, CMD_ACTIVE, 2'd1, 13'h0123);
        check_cmd("closed_bank", 1, CMD_READ, 2'd1, 13'd10);
        end_test("closed_bank");
    endtask

    task automatic row_hit_read();
        start_test();
        do_read({2'd1, 13'h0123, 7'd9});
        finish_reads("row_hit");
        if (cmd_log.size() != 1) fail_value("row_hit", "command count", 1, cmd_log.size());
        check_cmd("row_hit", 0, CMD_READ, 2'd1, 13'd18);
        if (got_cyc.size() > 0 && got_cyc[0] - ack_cyc != CAS_LAT + 3)
            fail_value("row_hit", "ack to data_ok", CAS_LAT + 3, got_cyc[0] - ack_cyc);
        end_test("row_hit");
    endtask

    task automatic row_miss_read();
        start_test();
        do_read({2'd1, 13'h1abc, 7'd100});
        finish_reads("row_miss");
        if (cmd_log.size() != 3) fail_value("row_miss", "command count", 3, cmd_log.size());
        check_cmd("row_miss", 0, CMD_PRECHARGE, 2'd1, 13'h0000);
        check_cmd("row_miss", 1, CMD_ACTIVE, 2'd1, 13'h1abc);
        check_cmd("row_miss", 2, CMD_READ, 2'd1, 13'd200);
        end_test("row_miss");
    endtask

    task automatic four_bank_overlap();
        start_test();
        for (int b = 0; b < NBANK; b++) begin
            do_read({bank_t'(b), row_t'(13'h0040 + b), 7'(3 * b + 1)});
        end
        finish_reads("overlap");
        end_test("overlap");
    endtask

    // few rows per bank so hits and misses mix
    task automatic random_reads();
        start_test();
        for (int i = 0; i < 30; i++) begin
            do_read({bank_t'($urandom_range(0, 3)), row_t'(13'h0200 + $urandom_range(0, 3)),
                     7'($urandom)});
        end
        finish_reads("random");
        end_test("random");
    endtask

    initial begin
        void'($urandom(42540));
        reset_outputs();
        closed_bank_read();
        row_hit_read();
        row_miss_read();
        four_bank_overlap();
        random_reads();
        $display("tests run: %0d, failed checks: %0d", tests_run, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* vlog.f */
sdram_cmd_pkg.sv
sdram_addr_pkg.sv
sdram_req_decode.sv
sdram_bank.sv
sdram_bus_arbiter.sv
sdram_rd_ctrl.sv
sdram_rd_ctrl_sva.sv
tb_sdram_rd_ctrl.sv
